// ==== hdl/axis_destruct_pkg.sv ====
// shared widths and types for the 64 to 16 bit stream downsizer
// only the ratio given by WIDE_BYTES / SLIM_BYTES is supported
// every byte travels with its keep bit as one 9-bit lane (keep above data)
package axis_destruct_pkg;

    // bytes per beat on each side
    localparam int WIDE_BYTES = 8;
    localparam int SLIM_BYTES = 2;

    // slim segments cut out of one wide beat
    localparam int NSIZE = WIDE_BYTES / SLIM_BYTES;

    // one lane is keep bit plus data byte
    localparam int LANE_W = 9;

    // wide side tdata and tkeep
    typedef logic [WIDE_BYTES*8-1:0] wide_data_t;
    typedef logic [WIDE_BYTES-1:0]   wide_keep_t;

    // slim side tdata and tkeep
    typedef logic [SLIM_BYTES*8-1:0] slim_data_t;
    typedef logic [SLIM_BYTES-1:0]   slim_keep_t;

    // packed lane words, lane 0 in the low bits
    typedef logic [WIDE_BYTES*LANE_W-1:0] wide_lanes_t;
    typedef logic [SLIM_BYTES*LANE_W-1:0] slim_lanes_t;

    // null-beat filter: hold register empty or occupied
    typedef enum logic {
        EMPTY,
        HOLD
    } filter_state_t;

endpackage

// ==== hdl/axis_reg_slice.sv ====
// valid/ready register slice with a skid buffer, full throughput
// both valid and ready leave this block from flops
// s_ready only drops once the skid register holds a beat
// payload registers carry no reset, only the valid flags do
module axis_reg_slice #(
    parameter int WIDTH = 8
) (
    input  logic             clock,
    input  logic             rst_n,
    input  logic [WIDTH-1:0] s_payload,
    input  logic             s_valid,
    output logic             s_ready,
    output logic [WIDTH-1:0] m_payload,
    output logic             m_valid,
    input  logic             m_ready
);

    // second storage slot, catches the beat accepted while output stalls
    logic [WIDTH-1:0] skid_payload;
    logic             skid_valid;

    // main register free to take a new value this cycle
    logic main_free;
    // upstream transfer
    logic s_fire;

    assign main_free = m_ready || !m_valid;
    assign s_fire    = s_valid && s_ready;

    // ready is a pure flop output, high unless the skid slot is taken
    assign s_ready = !skid_valid;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            m_valid    <= 1'b0;
            skid_valid <= 1'b0;
        end else begin
            if (main_free) begin
                // skid beat is older, drain it first
                if (skid_valid) begin
                    m_valid    <= 1'b1;
                    skid_valid <= 1'b0;
                end else begin
                    m_valid <= s_valid;
                end
            end else if (s_fire) begin
                // output stalled but upstream already sent, park it
                skid_valid <= 1'b1;
            end
        end
    end

    // payload path follows the same decisions as the flags above
    always_ff @(posedge clock) begin
        if (main_free) begin
            if (skid_valid) begin
                m_payload <= skid_payload;
            end else if (s_valid) begin
                m_payload <= s_payload;
            end
        end
        if (s_fire && !main_free) begin
            skid_payload <= s_payload;
        end
    end

    // a stalled output beat must not change under the consumer
    a_payload_stable : assert property (
        @(posedge clock) disable iff (!rst_n)
        (m_valid && !m_ready) |=> (m_valid && $stable(m_payload))
    ) else $error("axis_reg_slice: output beat changed while stalled");

endmodule

// ==== hdl/width_destruct.sv ====
// splits one wide lane word into NSIZE slim lane words, lowest lane first
// one segment per cycle, so a wide beat occupies NSIZE cycles at full ready
// wr_ready opens while the last segment leaves so back-to-back beats run
// without a bubble
// rd_last is only raised on the final segment of a beat marked wr_last
module width_destruct (
    input  logic                             clock,
    input  logic                             rst_n,
    input  axis_destruct_pkg::wide_lanes_t   wr_data,
    input  logic                             wr_vld,
    output logic                             wr_ready,
    input  logic                             wr_last,
    output axis_destruct_pkg::slim_lanes_t   rd_data,
    output logic                             rd_vld,
    output logic                             rd_last,
    input  logic                             rd_ready
);

    // segment width in bits and counter sizing
    localparam int SEG_W = $bits(axis_destruct_pkg::slim_lanes_t);
    localparam int CNT_W = (axis_destruct_pkg::NSIZE > 1) ?
                           $clog2(axis_destruct_pkg::NSIZE) : 1;
    localparam logic [CNT_W-1:0] LAST_SEG = CNT_W'(axis_destruct_pkg::NSIZE - 1);

    // accepted wide word, kept until its final segment is gone
    axis_destruct_pkg::wide_lanes_t word_q;
    // which segment is on rd_data
    logic [CNT_W-1:0] cnt;
    // last flag of the wide beat being split
    logic             last_q;

    logic on_last_seg;
    logic rd_fire;
    logic wr_fire;

    assign on_last_seg = (cnt == LAST_SEG);
    assign rd_fire     = rd_vld && rd_ready;
    assign wr_fire     = wr_vld && wr_ready;

    // empty, or emptying this cycle
    assign wr_ready = !rd_vld || (on_last_seg && rd_ready);

    // segment mux with lane 0 in the low bits
    assign rd_data = word_q[cnt*SEG_W +: SEG_W];
    assign rd_last = rd_vld && last_q && on_last_seg;

    // control state
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            rd_vld <= 1'b0;
            cnt    <= '0;
            last_q <= 1'b0;
        end else begin
            if (wr_fire) begin
                // new beat starts at segment 0 next cycle
                rd_vld <= 1'b1;
                cnt    <= '0;
                last_q <= wr_last;
            end else if (rd_fire) begin
                if (on_last_seg) begin
                    rd_vld <= 1'b0;
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end
        end
    end

    // wide word holder
    always_ff @(posedge clock) begin
        if (wr_fire) begin
            word_q <= wr_data;
        end
    end

    // once offered, a segment stays put until the consumer takes it
    a_rd_hold : assert property (
        @(posedge clock) disable iff (!rst_n)
        (rd_vld && !rd_ready) |=> (rd_vld && $stable(rd_data) && $stable(rd_last))
    ) else $error("width_destruct: rd side dropped or changed a pending segment");

endmodule

// ==== hdl/null_beat_filter.sv ====
// removes slim segments whose keep bits are all zero
// one kept segment is held back until the next kept segment or a last
// arrives, so a dropped last can be moved onto it
// latency varies, out_valid marks when the held segment may leave
// a packet made of null segments only produces nothing
module null_beat_filter (
    input  logic                             clock,
    input  logic                             rst_n,
    input  axis_destruct_pkg::slim_lanes_t   in_data,
    input  logic                             in_valid,
    output logic                             in_ready,
    input  logic                             in_last,
    output axis_destruct_pkg::slim_lanes_t   out_data,
    output logic                             out_valid,
    output logic                             out_last,
    input  logic                             out_ready
);

    axis_destruct_pkg::filter_state_t state;

    // held kept segment and whether it already owns the packet last
    axis_destruct_pkg::slim_lanes_t hold_data;
    logic                           hold_last;

    logic in_null;
    logic hold_full;
    logic in_fire;
    logic out_fire;

    // keep bit sits on top of every 9-bit lane
    always_comb begin
        in_null = 1'b1;
        for (int i = 0; i < axis_destruct_pkg::SLIM_BYTES; i++) begin
            if (in_data[i*axis_destruct_pkg::LANE_W + 8]) begin
                in_null = 1'b0;
            end
        end
    end

    assign hold_full = (state == axis_destruct_pkg::HOLD);

    // held beat may go once it has last, or a kept successor shows up
    assign out_valid = hold_full && (hold_last || (in_valid && !in_null));
    assign out_data  = hold_data;
    assign out_last  = hold_last;

    // null segments are always swallowed
    // a kept one needs the hold slot free or leaving this cycle
    assign in_ready = !hold_full || in_null || out_ready;

    assign in_fire  = in_valid && in_ready;
    assign out_fire = out_valid && out_ready;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state     <= axis_destruct_pkg::EMPTY;
            hold_last <= 1'b0;
        end else begin
            if (in_fire && !in_null) begin
                // kept segment takes the slot, any previous one left via out_fire
                state     <= axis_destruct_pkg::HOLD;
                hold_last <= in_last;
            end else if (in_fire && in_last && hold_full && !hold_last) begin
                // null tail of a packet, its last moves onto the held segment
                hold_last <= 1'b1;
            end else if (out_fire) begin
                state     <= axis_destruct_pkg::EMPTY;
                hold_last <= 1'b0;
            end
        end
    end

    // payload slot, only ever loaded with kept segments
    always_ff @(posedge clock) begin
        if (in_fire && !in_null) begin
            hold_data <= in_data;
        end
    end

    // nothing empty may leave, the hold slot only takes kept segments
    a_no_null_out : assert property (
        @(posedge clock) disable iff (!rst_n)
        out_valid |-> (out_data[8] || out_data[axis_destruct_pkg::LANE_W + 8])
    ) else $error("null_beat_filter: presented a segment with no keep bit set");

endmodule

// ==== hdl/axis_width_destruct.sv ====
// 64-bit to 16-bit stream downsizer with null-beat removal
// keep is assumed contiguous from the low byte inside each wide beat
// pipeline: input slice, serializer, null filter, output slice
// no tuser/tid/tdest and no configuration
module axis_width_destruct (
    input  logic                           clock,
    input  logic                           rst_n,
    input  axis_destruct_pkg::wide_data_t  s_tdata,
    input  axis_destruct_pkg::wide_keep_t  s_tkeep,
    input  logic                           s_tvalid,
    output logic                           s_tready,
    input  logic                           s_tlast,
    output axis_destruct_pkg::slim_data_t  m_tdata,
    output axis_destruct_pkg::slim_keep_t  m_tkeep,
    output logic                           m_tvalid,
    input  logic                           m_tready,
    output logic                           m_tlast
);

    localparam int IN_W  = $bits(axis_destruct_pkg::wide_lanes_t) + 1;
    localparam int OUT_W = $bits(axis_destruct_pkg::slim_lanes_t) + 1;

    // lane words on each side
    axis_destruct_pkg::wide_lanes_t s_lanes;
    axis_destruct_pkg::wide_lanes_t wd_lanes;
    axis_destruct_pkg::slim_lanes_t seg_lanes;
    axis_destruct_pkg::slim_lanes_t flt_lanes;
    axis_destruct_pkg::slim_lanes_t m_lanes;

    // handshakes between stages
    logic wd_valid, wd_ready, wd_last;
    logic seg_valid, seg_ready, seg_last;
    logic flt_valid, flt_ready, flt_last;

    // pack keep bit above its data byte, lane i for byte i
    always_comb begin
        for (int i = 0; i < axis_destruct_pkg::WIDE_BYTES; i++) begin
            s_lanes[i*axis_destruct_pkg::LANE_W +: axis_destruct_pkg::LANE_W] =
                {s_tkeep[i], s_tdata[i*8 +: 8]};
        end
    end

    // unpack the output lanes back into keep and data
    always_comb begin
        for (int i = 0; i < axis_destruct_pkg::SLIM_BYTES; i++) begin
            {m_tkeep[i], m_tdata[i*8 +: 8]} =
                m_lanes[i*axis_destruct_pkg::LANE_W +: axis_destruct_pkg::LANE_W];
        end
    end

    axis_reg_slice #(
        .WIDTH (IN_W)
    ) in_slice (
        .clock     (clock),
        .rst_n     (rst_n),
        .s_payload ({s_lanes, s_tlast}),
        .s_valid   (s_tvalid),
        .s_ready   (s_tready),
        .m_payload ({wd_lanes, wd_last}),
        .m_valid   (wd_valid),
        .m_ready   (wd_ready)
    );

    width_destruct u_width_destruct (
        .clock    (clock),
        .rst_n    (rst_n),
        .wr_data  (wd_lanes),
        .wr_vld   (wd_valid),
        .wr_ready (wd_ready),
        .wr_last  (wd_last),
        .rd_data  (seg_lanes),
        .rd_vld   (seg_valid),
        .rd_last  (seg_last),
        .rd_ready (seg_ready)
    );

    null_beat_filter u_null_beat_filter (
        .clock     (clock),
        .rst_n     (rst_n),
        .in_data   (seg_lanes),
        .in_valid  (seg_valid),
        .in_ready  (seg_ready),
        .in_last   (seg_last),
        .out_data  (flt_lanes),
        .out_valid (flt_valid),
        .out_last  (flt_last),
        .out_ready (flt_ready)
    );

    axis_reg_slice #(
        .WIDTH (OUT_W)
    ) out_slice (
        .clock     (clock),
        .rst_n     (rst_n),
        .s_payload ({flt_lanes, flt_last}),
        .s_valid   (flt_valid),
        .s_ready   (flt_ready),
        .m_payload ({m_lanes, m_tlast}),
        .m_valid   (m_tvalid),
        .m_ready   (m_tready)
    );

endmodule

// ==== sim/tb_clock_gen.sv ====
// clock and reset source for the downsizer testbench
// 100 ns period, rst_n held low for the first 8 rising edges
// reset is released on a rising edge, like any other driven input
module tb_clock_gen (
    output logic clock,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int HALF_PERIOD  = 50;
    localparam int RESET_CYCLES = 8;

    initial begin
        clock = 1'b0;
        forever #HALF_PERIOD clock = ~clock;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        rst_n <= 1'b1;
    end

endmodule

// ==== sim/tb_axis_width_destruct.sv ====
// testbench for the 64 to 16 bit stream downsizer
// a fixed table of wide beats is driven in order, m_tready follows a seeded random pattern
// expected slim beats are built from the table by the lane and null rules
// keep in the table is contiguous from the low byte, as the DUT assumes
// outputs and s_tready are sampled on the falling edge, inputs change on the rising edge
module tb_axis_width_destruct;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NBEATS          = 11;
    localparam int RAND_SEED       = 48897;
    localparam int SEG_BYTES       = axis_destruct_pkg::SLIM_BYTES;
    localparam int WATCHDOG_CYCLES = NBEATS * axis_destruct_pkg::NSIZE * 4 + 100;
    localparam int DRAIN_CYCLES    = 64;
    localparam int QUIET_CYCLES    = 16;

    // test ids, printable names come from test_name()
    localparam int T_FULL      = 0;
    localparam int T_PARTIAL   = 1;
    localparam int T_NULL_TAIL = 2;
    localparam int T_NULL_PKT  = 3;
    localparam int T_SHORT     = 4;
    localparam int T_MID_NULL  = 5;

    typedef struct packed {
        int                            test;
        axis_destruct_pkg::wide_data_t data;
        axis_destruct_pkg::wide_keep_t keep;
        logic                          last;
    } wide_beat_t;

    typedef struct packed {
        int                            test;
        axis_destruct_pkg::slim_data_t data;
        axis_destruct_pkg::slim_keep_t keep;
        logic                          last;
    } slim_beat_t;

    // stimulus table, one row per wide beat, packets end on last
    localparam wide_beat_t BEATS [NBEATS] = '{
        '{T_FULL,      64'h0706_0504_0302_0100, 8'hff, 1'b0},
        '{T_FULL,      64'h0f0e_0d0c_0b0a_0908, 8'hff, 1'b1},
        '{T_PARTIAL,   64'h1716_1514_1312_1110, 8'hff, 1'b0},
        '{T_PARTIAL,   64'h1f1e_1d1c_1b1a_1918, 8'h07, 1'b1},
        '{T_NULL_TAIL, 64'h2726_2524_2322_2120, 8'hff, 1'b0},
        '{T_NULL_TAIL, 64'h2f2e_2d2c_2b2a_2928, 8'h00, 1'b1},
        '{T_NULL_PKT,  64'h3736_3534_3332_3130, 8'h00, 1'b1},
        '{T_SHORT,     64'h4746_4544_4342_4140, 8'h01, 1'b1},
        '{T_MID_NULL,  64'h5756_5554_5352_5150, 8'hff, 1'b0},
        '{T_MID_NULL,  64'h5f5e_5d5c_5b5a_5958, 8'h0f, 1'b0},
        '{T_MID_NULL,  64'h6766_6564_6362_6160, 8'hff, 1'b1}
    };

    logic                          clock;
    logic                          rst_n;
    axis_destruct_pkg::wide_data_t s_tdata;
    axis_destruct_pkg::wide_keep_t s_tkeep;
    logic                          s_tvalid;
    logic                          s_tready;
    logic                          s_tlast;
    axis_destruct_pkg::slim_data_t m_tdata;
    axis_destruct_pkg::slim_keep_t m_tkeep;
    logic                          m_tvalid;
    logic                          m_tready;
    logic                          m_tlast;

    // expected slim beats, front is the next one due
    slim_beat_t exp_q [$];

    int beats_checked;
    int value_errors;
    int extra_beats;
    int flow_errors;

    tb_clock_gen clk_gen (
        .clock (clock),
        .rst_n (rst_n)
    );

    axis_width_destruct UUT (
        .clock    (clock),
        .rst_n    (rst_n),
        .s_tdata  (s_tdata),
        .s_tkeep  (s_tkeep),
        .s_tvalid (s_tvalid),
        .s_tready (s_tready),
        .s_tlast  (s_tlast),
        .m_tdata  (m_tdata),
        .m_tkeep  (m_tkeep),
        .m_tvalid (m_tvalid),
        .m_tready (m_tready),
        .m_tlast  (m_tlast)
    );

    function automatic string test_name(input int id);
        case (id)
            T_FULL:      return "full_keep";
            T_PARTIAL:   return "partial_tail";
            T_NULL_TAIL: return "null_tail";
            T_NULL_PKT:  return "null_packet";
            T_SHORT:     return "single_byte";
            T_MID_NULL:  return "mid_packet_nulls";
            default:     return "unknown";
        endcase
    endfunction

    // two-byte lanes low first, null lanes dropped, last on the final kept lane
    task automatic build_expected();
        slim_beat_t                    pend;
        logic                          have_pend;
        axis_destruct_pkg::slim_keep_t seg_keep;
        have_pend = 1'b0;
        pend      = '0;
        for (int i = 0; i < NBEATS; i++) begin
            for (int s = 0; s < axis_destruct_pkg::NSIZE; s++) begin
                seg_keep = BEATS[i].keep[s*SEG_BYTES +: SEG_BYTES];
                if (seg_keep != '0) begin
                    // a newer kept lane exists, so the pending one is not the end
                    if (have_pend) begin
                        exp_q.push_back(pend);
                    end
                    pend.test = BEATS[i].test;
                    pend.data = BEATS[i].data[s*SEG_BYTES*8 +: SEG_BYTES*8];
                    pend.keep = seg_keep;
                    pend.last = 1'b0;
                    have_pend = 1'b1;
                end
            end
            // packets with nothing kept add no beat
            if (BEATS[i].last && have_pend) begin
                pend.last = 1'b1;
                exp_q.push_back(pend);
                have_pend = 1'b0;
            end
        end
    endtask

    // one wide beat per row, held until the input slice is ready
    task automatic drive_beats();
        for (int i = 0; i < NBEATS; i++) begin
            s_tdata  <= BEATS[i].data;
            s_tkeep  <= BEATS[i].keep;
            s_tlast  <= BEATS[i].last;
            s_tvalid <= 1'b1;
            @(negedge clock);
            while (!s_tready) begin
                @(negedge clock);
            end
            // transfer on this edge
            @(posedge clock);
        end
        s_tvalid <= 1'b0;
    endtask

    task automatic check_output();
        slim_beat_t want;
        if (exp_q.size() == 0) begin
            extra_beats++;
            $display("extra output beat: tdata %h tkeep %b came after all expected beats",
                     m_tdata, m_tkeep);
        end else begin
            want = exp_q.pop_front();
            beats_checked++;
            if (m_tdata !== want.data) begin
                value_errors++;
                $display("ERROR %s: tdata expected %h actual %h",
                         test_name(want.test), want.data, m_tdata);
            end
            if (m_tkeep !== want.keep) begin
                value_errors++;
                $display("ERROR %s: tkeep expected %b actual %b",
                         test_name(want.test), want.keep, m_tkeep);
            end
            if (m_tlast !== want.last) begin
                value_errors++;
                $display("ERROR %s: tlast expected %b actual %b",
                         test_name(want.test), want.last, m_tlast);
            end
        end
    endtask

    task automatic print_counts();
        $display("checked %0d beats: %0d value errors, %0d extra beats, %0d other errors",
                 beats_checked, value_errors, extra_beats, flow_errors);
    endtask

    // output monitor, a transfer happens on the next rising edge
    initial begin
        beats_checked = 0;
        value_errors  = 0;
        extra_beats   = 0;
        build_expected();
        forever begin
            @(negedge clock);
            if (rst_n && m_tvalid && m_tready) begin
                check_output();
            end
        end
    end

    // random back-pressure, about three cycles in four ready
    initial begin
        m_tready = 1'b0;
        void'($urandom(RAND_SEED));
        @(posedge rst_n);
        forever begin
            @(posedge clock);
            m_tready <= ($urandom % 4) != 0;
        end
    end

    initial begin
        int drain;
        s_tdata     = '0;
        s_tkeep     = '0;
        s_tvalid    = 1'b0;
        s_tlast     = 1'b0;
        flow_errors = 0;
        drain       = 0;
        @(posedge rst_n);
        @(negedge clock);
        // idle pipeline right after reset
        if (m_tvalid !== 1'b0) begin
            flow_errors++;
            $display("ERROR reset_state: m_tvalid expected 0 actual %b", m_tvalid);
        end
        if (s_tready !== 1'b1) begin
            flow_errors++;
            $display("ERROR reset_state: s_tready expected 1 actual %b", s_tready);
        end
        @(posedge clock);
        drive_beats();
        while (exp_q.size() != 0 && drain < DRAIN_CYCLES) begin
            @(posedge clock);
            drain++;
        end
        if (exp_q.size() != 0) begin
            flow_errors++;
            $display("%0d expected output beats never came out of the DUT", exp_q.size());
        end
        // watch for late duplicates
        repeat (QUIET_CYCLES) @(posedge clock);
        print_counts();
        if (value_errors + extra_beats + flow_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        $display("timeout: run still busy after %0d clock cycles", WATCHDOG_CYCLES);
        print_counts();
        $display("TB FAILED");
        $finish;
    end

endmodule

// ==== compile.f ====
hdl/axis_destruct_pkg.sv
hdl/axis_reg_slice.sv
hdl/width_destruct.sv
hdl/null_beat_filter.sv
hdl/axis_width_destruct.sv
sim/tb_clock_gen.sv
sim/tb_axis_width_destruct.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds and runs the downsizer testbench with Verilator
# exit status 0 only when the log holds no failure report

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=sim_tb
LOG=sim.log

verilator --binary --timing --assert -j 0 \
    --timescale 1ns/100ps \
    -f compile.f \
    --top-module tb_axis_width_destruct \
    -Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "TB FAILED" "$LOG"; then
    echo "simulation reported a failure, see $LOG"
    exit 1
fi
if ! grep -q "TB PASSED" "$LOG"; then
    echo "simulation ended without a result line, see $LOG"
    exit 1
fi
exit 0
